/* Makefile */
TOP = tb_enigma_top
LOG = sim.log

.PHONY: test clean help

test:
	verilator --binary --timing -f tb.f --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG); cat $(LOG)
	grep -q ">>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

help:
	@echo "test  - build with Verilator, run, check the log"
	@echo "clean - remove obj_dir and the log"
	@echo "help  - list these targets"

/* common/enigma_cfg.svh */
`ifndef ENIGMA_CFG_SVH
`define ENIGMA_CFG_SVH

// letter codes, 0..25 map to A..Z
`define LETTER_W 5
// one rotor choice field, 0..4 for rotors I..V
`define ROTOR_SEL_W 3
`define NUM_ROTORS 3

// infrared pulse widths in clock cycles
`define IR_START_CYCLES 64
`define IR_MARK_CYCLES 16
`define IR_SPACE0_CYCLES 16
`define IR_SPACE1_CYCLES 48
// high longer than this aborts a frame
`define IR_IDLE_CYCLES 128

// seven-segment scan, cycles per digit
`define SEG_SCAN_CYCLES 16

`endif

/* common/enigma_pkg.sv */
`include "enigma_cfg.svh"

package enigma_pkg;

  // one letter, A=0 .. Z=25
  typedef logic [`LETTER_W-1:0] letter_t;

  // rotor choices, left rotor in the top field
  typedef logic [`NUM_ROTORS*`ROTOR_SEL_W-1:0] rotor_sel_t;

  // start positions, left rotor in the top field
  typedef logic [`NUM_ROTORS*`LETTER_W-1:0] rotor_pos_t;

  // infrared frame decoder
  typedef enum logic [1:0] {
    IR_IDLE,
    IR_START,
    IR_SPACE,
    IR_MARK
  } ir_state_t;

  // encipher sequence, one rotor per cycle
  typedef enum logic [2:0] {
    EN_IDLE,
    EN_STEP,
    EN_FWD,
    EN_REFLECT,
    EN_BACK,
    EN_DONE
  } enigma_state_t;

endpackage

/* design/enigma_top.sv */
module enigma_top
  import enigma_pkg::*;
(
  input  logic        clk_100_passthrough,
  input  logic        rst_n,
  input  logic        ir_in,
  input  logic [15:0] sw,
  input  logic        config_load,
  output logic        ready,
  output letter_t     cipher_letter,
  output logic        cipher_valid,
  output letter_t     plain_letter,
  output logic        plain_valid,
  output logic [7:0]  seg_an,
  output logic [6:0]  seg_cat
);

  rotor_sel_t rotor_sel;
  rotor_pos_t rotor_pos;
  logic       rotor_load;

  // infrared line to plaintext letters
  ir_receiver u_ir_receiver (
    .clk_100_passthrough (clk_100_passthrough),
    .rst_n               (rst_n),
    .ir_in               (ir_in),
    .plain_letter        (plain_letter),
    .plain_valid         (plain_valid)
  );

  // switch-loaded rotor setup
  rotor_config u_rotor_config (
    .clk_100_passthrough (clk_100_passthrough),
    .rst_n               (rst_n),
    .sw                  (sw),
    .config_load         (config_load),
    .rotor_sel           (rotor_sel),
    .rotor_pos           (rotor_pos),
    .rotor_load          (rotor_load)
  );

  // letters arriving while busy are dropped here
  enigma_core u_enigma_core (
    .clk_100_passthrough (clk_100_passthrough),
    .rst_n               (rst_n),
    .rotor_sel           (rotor_sel),
    .rotor_pos           (rotor_pos),
    .rotor_load          (rotor_load),
    .plain_letter        (plain_letter),
    .plain_valid         (plain_valid),
    .ready               (ready),
    .cipher_letter       (cipher_letter),
    .cipher_valid        (cipher_valid)
  );

  seg_display u_seg_display (
    .clk_100_passthrough (clk_100_passthrough),
    .rst_n               (rst_n),
    .plain_letter        (plain_letter),
    .plain_valid         (plain_valid),
    .cipher_letter       (cipher_letter),
    .cipher_valid        (cipher_valid),
    .seg_an              (seg_an),
    .seg_cat             (seg_cat)
  );

endmodule

/* design/seg_display.sv */
`include "enigma_cfg.svh"

module seg_display
  import enigma_pkg::*;
(
  input  logic       clk_100_passthrough,
  input  logic       rst_n,
  input  letter_t    plain_letter,
  input  logic       plain_valid,
  input  letter_t    cipher_letter,
  input  logic       cipher_valid,
  output logic [7:0] seg_an,
  output logic [6:0] seg_cat
);

  localparam int SCAN_W = $clog2(`SEG_SCAN_CYCLES);

  letter_t           plain_hold;
  letter_t           cipher_hold;
  logic [SCAN_W-1:0] scan_cnt;
  logic [2:0]        digit;
  logic [2:0]        digit_next;
  logic [3:0]        nibble;
  logic [6:0]        font;

  assign digit_next = digit + 3'd1;

  always_ff @(posedge clk_100_passthrough or negedge rst_n) begin
    if (!rst_n) begin
      plain_hold  <= '0;
      cipher_hold <= '0;
      scan_cnt    <= '0;
      // first step lights digit 0
      digit       <= 3'd7;
      seg_an      <= 8'hff;
    end else begin
      if (plain_valid) plain_hold <= plain_letter;
      if (cipher_valid) cipher_hold <= cipher_letter;
      if (scan_cnt == SCAN_W'(`SEG_SCAN_CYCLES - 1)) begin
        scan_cnt <= '0;
        digit    <= digit_next;
        seg_an   <= ~(8'd1 << digit_next);
      end else begin
        scan_cnt <= scan_cnt + 1'b1;
      end
    end
  end

  // cipher on digits 1:0, plain on 5:4
  always_comb begin
    case (digit)
      3'd0:    nibble = cipher_hold[3:0];
      3'd1:    nibble = {3'b000, cipher_hold[4]};
      3'd4:    nibble = plain_hold[3:0];
      3'd5:    nibble = {3'b000, plain_hold[4]};
      default: nibble = 4'h0;
    endcase
    // gfedcba, lit high
    case (nibble)
      4'h0: font = 7'h3f;
      4'h1: font = 7'h06;
      4'h2: font = 7'h5b;
      4'h3: font = 7'h4f;
      4'h4: font = 7'h66;
      4'h5: font = 7'h6d;
      4'h6: font = 7'h7d;
      4'h7: font = 7'h07;
      4'h8: font = 7'h7f;
      4'h9: font = 7'h6f;
      4'ha: font = 7'h77;
      4'hb: font = 7'h7c;
      4'hc: font = 7'h39;
      4'hd: font = 7'h5e;
      4'he: font = 7'h79;
      default: font = 7'h71;
    endcase
  end

  // cathodes active low
  assign seg_cat = ~font;

endmodule

/* enigma/enigma_core.sv */
`include "enigma_cfg.svh"

module enigma_core
  import enigma_pkg::*;
(
  input  logic       clk_100_passthrough,
  input  logic       rst_n,
  input  rotor_sel_t rotor_sel,
  input  rotor_pos_t rotor_pos,
  input  logic       rotor_load,
  input  letter_t    plain_letter,
  input  logic       plain_valid,
  output logic       ready,
  output letter_t    cipher_letter,
  output logic       cipher_valid
);

  // wiring tables as ascii, index 0 in the top byte
  localparam logic [207:0] ROTOR_I   = "EKMFLGDQVZNTOWYHXUSPAIBRCJ";
  localparam logic [207:0] ROTOR_II  = "AJDKSIRUXBLHWTMCQGZNPYFVOE";
  localparam logic [207:0] ROTOR_III = "BDFHJLCPRTXVZNYEIWGAKMUSQO";
  localparam logic [207:0] ROTOR_IV  = "ESOVPZJAYQUIRHXLNFTGKDCMWB";
  localparam logic [207:0] ROTOR_V   = "VZBRGITYUPSDNHLXAWMJQOKCEF";
  localparam logic [207:0] REFL_B    = "YRUHQSLDPXNGOKMIEBFZCWVJAT";

  function automatic letter_t add26(letter_t a, letter_t b);
    logic [`LETTER_W:0] s;
    s = a + b;
    if (s >= 26) s = s - 26;
    return s[`LETTER_W-1:0];
  endfunction

  function automatic letter_t sub26(letter_t a, letter_t b);
    if (a >= b) return a - b;
    return a + letter_t'(26) - b;
  endfunction

  // codes 26..31 load as A
  function automatic letter_t clamp26(letter_t p);
    return (p < 26) ? p : '0;
  endfunction

  // choices 5..7 fall back to rotor I
  function automatic logic [207:0] wiring(logic [`ROTOR_SEL_W-1:0] sel);
    case (sel)
      3'd1:    return ROTOR_II;
      3'd2:    return ROTOR_III;
      3'd3:    return ROTOR_IV;
      3'd4:    return ROTOR_V;
      default: return ROTOR_I;
    endcase
  endfunction

  // notches Q, E, V, J, Z
  function automatic letter_t notch(logic [`ROTOR_SEL_W-1:0] sel);
    case (sel)
      3'd1:    return letter_t'(4);
      3'd2:    return letter_t'(21);
      3'd3:    return letter_t'(9);
      3'd4:    return letter_t'(25);
      default: return letter_t'(16);
    endcase
  endfunction

  function automatic letter_t tap(logic [207:0] tbl, letter_t idx);
    logic [7:0] ch;
    ch = tbl[8*(25-idx) +: 8];
    return letter_t'(ch - 8'd65);
  endfunction

  // inverse wiring by search over the forward table
  function automatic letter_t untap(logic [207:0] tbl, letter_t val);
    letter_t r;
    r = '0;
    for (int j = 0; j < 26; j++) begin
      if (tap(tbl, letter_t'(j)) == val) r = letter_t'(j);
    end
    return r;
  endfunction

  enigma_state_t          state;
  // index 0 is the left rotor
  logic [`ROTOR_SEL_W-1:0] sel_r [`NUM_ROTORS];
  letter_t                 pos_r [`NUM_ROTORS];
  letter_t                 cur;
  logic [1:0]              stage;
  logic [1:0]              rot_idx;
  logic [207:0]            rot_tbl;
  letter_t                 rot_in;
  letter_t                 fwd_out;
  letter_t                 back_out;
  letter_t                 refl_out;
  logic                    right_at;
  logic                    mid_at;
  logic                    accept;

  assign ready  = (state == EN_IDLE);
  assign accept = ready && plain_valid && (plain_letter < 26);

  assign right_at = (pos_r[2] == notch(sel_r[2]));
  assign mid_at   = (pos_r[1] == notch(sel_r[1]));

  // forward goes right to left, back left to right
  always_comb begin
    rot_idx  = (state == EN_FWD) ? 2'd2 - stage : stage;
    rot_tbl  = wiring(sel_r[rot_idx]);
    rot_in   = add26(cur, pos_r[rot_idx]);
    fwd_out  = sub26(tap(rot_tbl, rot_in), pos_r[rot_idx]);
    back_out = sub26(untap(rot_tbl, rot_in), pos_r[rot_idx]);
    refl_out = tap(REFL_B, cur);
  end

  always_ff @(posedge clk_100_passthrough or negedge rst_n) begin
    if (!rst_n) begin
      state         <= EN_IDLE;
      stage         <= '0;
      sel_r         <= '{3'd0, 3'd1, 3'd2};
      pos_r         <= '{default: '0};
      cipher_letter <= '0;
      cipher_valid  <= 1'b0;
    end else begin
      cipher_valid <= 1'b0;
      case (state)
        EN_IDLE: begin
          // load is ignored outside idle
          if (rotor_load) begin
            for (int i = 0; i < `NUM_ROTORS; i++) begin
              sel_r[i] <= rotor_sel[`ROTOR_SEL_W*(`NUM_ROTORS-1-i) +: `ROTOR_SEL_W];
              pos_r[i] <= clamp26(rotor_pos[`LETTER_W*(`NUM_ROTORS-1-i) +: `LETTER_W]);
            end
          end
          if (accept) state <= EN_STEP;
        end
        EN_STEP: begin
          pos_r[2] <= add26(pos_r[2], letter_t'(1));
          // middle also moves on its own notch, double step
          if (right_at || mid_at) pos_r[1] <= add26(pos_r[1], letter_t'(1));
          if (mid_at) pos_r[0] <= add26(pos_r[0], letter_t'(1));
          stage <= '0;
          state <= EN_FWD;
        end
        EN_FWD: begin
          stage <= stage + 1'b1;
          if (stage == 2'd2) state <= EN_REFLECT;
        end
        EN_REFLECT: begin
          stage <= '0;
          state <= EN_BACK;
        end
        EN_BACK: begin
          stage <= stage + 1'b1;
          if (stage == 2'd2) begin
            // right rotor out, strobe sits in the done cycle
            cipher_letter <= back_out;
            cipher_valid  <= 1'b1;
            state         <= EN_DONE;
          end
        end
        EN_DONE: begin
          state <= EN_IDLE;
        end
        default: state <= EN_IDLE;
      endcase
    end
  end

  // letter in flight
  always_ff @(posedge clk_100_passthrough) begin
    case (state)
      EN_IDLE:    if (accept) cur <= plain_letter;
      EN_FWD:     cur <= fwd_out;
      EN_REFLECT: cur <= refl_out;
      EN_BACK:    cur <= back_out;
      default:    cur <= cur;
    endcase
  end

endmodule

/* enigma/rotor_config.sv */
module rotor_config
  import enigma_pkg::*;
(
  input  logic        clk_100_passthrough,
  input  logic        rst_n,
  input  logic [15:0] sw,
  input  logic        config_load,
  output rotor_sel_t  rotor_sel,
  output rotor_pos_t  rotor_pos,
  output logic        rotor_load
);

  // sw[15] picks the field being loaded
  always_ff @(posedge clk_100_passthrough or negedge rst_n) begin
    if (!rst_n) begin
      // rotors I, II, III left to right
      rotor_sel  <= {3'd0, 3'd1, 3'd2};
      // start at AAA
      rotor_pos  <= '0;
      rotor_load <= 1'b0;
    end else begin
      rotor_load <= 1'b0;
      if (config_load) begin
        if (sw[15]) begin
          rotor_pos  <= sw[14:0];
          // positions land first, core copies both next cycle
          rotor_load <= 1'b1;
        end else begin
          rotor_sel <= sw[8:0];
        end
      end
    end
  end

endmodule

/* ir/ir_receiver.sv */
`include "enigma_cfg.svh"

module ir_receiver
  import enigma_pkg::*;
(
  input  logic    clk_100_passthrough,
  input  logic    rst_n,
  input  logic    ir_in,
  output letter_t plain_letter,
  output logic    plain_valid
);

  // counter must reach past the idle limit
  localparam int CNT_W = $clog2(`IR_IDLE_CYCLES + 2);

  localparam logic [CNT_W-1:0] START_LEN = CNT_W'(`IR_START_CYCLES);
  localparam logic [CNT_W-1:0] IDLE_LEN = CNT_W'(`IR_IDLE_CYCLES);
  // midpoint between a 0 space and a 1 space
  localparam logic [CNT_W-1:0] BIT_MID =
    CNT_W'((`IR_SPACE0_CYCLES + `IR_SPACE1_CYCLES) / 2);
  localparam logic [CNT_W-1:0] SHORT_LEN = CNT_W'(`IR_SPACE0_CYCLES / 2);
  // marks under half length count as glitches
  localparam logic [CNT_W-1:0] GLITCH_LEN = CNT_W'(`IR_MARK_CYCLES / 2);

  logic [1:0]            ir_sync;
  logic                  ir_line;
  ir_state_t             state;
  logic [CNT_W-1:0]      cnt;
  logic [CNT_W-1:0]      cnt_inc;
  logic [2:0]            bit_cnt;
  logic [`LETTER_W-2:0]  shift_q;
  logic                  space_bit;

  assign ir_line = ir_sync[1];

  // saturate, long lows just stay at max
  assign cnt_inc = (cnt == '1) ? cnt : cnt + 1'b1;

  // long space means a 1
  assign space_bit = (cnt >= BIT_MID);

  always_ff @(posedge clk_100_passthrough or negedge rst_n) begin
    if (!rst_n) begin
      ir_sync      <= 2'b11;
      state        <= IR_IDLE;
      cnt          <= '0;
      bit_cnt      <= '0;
      plain_letter <= '0;
      plain_valid  <= 1'b0;
    end else begin
      ir_sync     <= {ir_sync[0], ir_in};
      plain_valid <= 1'b0;
      case (state)
        IR_IDLE: begin
          if (!ir_line) begin
            state <= IR_START;
            cnt   <= CNT_W'(1);
          end
        end
        IR_START: begin
          if (!ir_line) begin
            cnt <= cnt_inc;
          end else if (cnt >= START_LEN) begin
            state   <= IR_SPACE;
            cnt     <= CNT_W'(1);
            bit_cnt <= '0;
          end else begin
            // too short for a start mark
            state <= IR_IDLE;
          end
        end
        IR_SPACE: begin
          if (ir_line) begin
            // idle abort
            if (cnt >= IDLE_LEN) begin
              state <= IR_IDLE;
            end else begin
              cnt <= cnt_inc;
            end
          end else if (cnt < SHORT_LEN) begin
            state <= IR_IDLE;
          end else if (bit_cnt == 3'(`LETTER_W - 1)) begin
            // fifth space closed, letter complete
            plain_letter <= {shift_q, space_bit};
            plain_valid  <= 1'b1;
            state        <= IR_IDLE;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
            state   <= IR_MARK;
            cnt     <= CNT_W'(1);
          end
        end
        IR_MARK: begin
          if (!ir_line) begin
            cnt <= cnt_inc;
          end else if (cnt < GLITCH_LEN) begin
            state <= IR_IDLE;
          end else begin
            state <= IR_SPACE;
            cnt   <= CNT_W'(1);
          end
        end
        default: state <= IR_IDLE;
      endcase
    end
  end

  // msb first, last bit joins at the output
  always_ff @(posedge clk_100_passthrough) begin
    if (state == IR_SPACE && !ir_line) begin
      shift_q <= {shift_q[`LETTER_W-3:0], space_bit};
    end
  end

endmodule

/* sim/enigma_stimulus.txt */
# kind then hex fields: C rotor_sel rotor_pos | L plain expected_cipher
# B space_len (bad frame) | R (reset); rotors I II III reflector B
L 00 01
L 00 03
L 00 19
L 00 06
L 00 0e
B 04
B c8
L 00 16
R
L 00 01
C 00a 0074
L 00 04
L 01 04
L 02 14
C 00a 0074
L 04 00
L 04 01
L 14 02

/* sim/tb_enigma_top.sv */
`include "enigma_cfg.svh"

module tb_enigma_top
  import enigma_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  // accepted plain_valid to cipher_valid
  localparam int CORE_LATENCY = 9;
  localparam int RX_LATENCY = 3;
  localparam int START_LEN = `IR_START_CYCLES + 8;
  localparam int LETTER_TIMEOUT = 200;
  localparam int BAD_WINDOW = 60;
  // longest record, a full frame of long spaces plus its wait
  localparam int WORST_CYCLES =
    START_LEN + 5 * (`IR_IDLE_CYCLES * 2 + `IR_MARK_CYCLES) + LETTER_TIMEOUT;

  logic        clk_100_passthrough;
  logic        rst_n;
  logic        ir_in;
  logic [15:0] sw;
  logic        config_load;
  logic        ready;
  letter_t     cipher_letter;
  logic        cipher_valid;
  letter_t     plain_letter;
  logic        plain_valid;
  logic [7:0]  seg_an;
  logic [6:0]  seg_cat;

  int      cyc;
  int      checks;
  int      value_errors;
  int      other_errors;
  int      pv_count;
  int      cv_count;
  int      pv_cyc;
  int      cv_cyc;
  letter_t pv_letter;
  letter_t cv_letter;
  letter_t exp_plain;
  letter_t exp_cipher;
  letter_t held_plain;
  letter_t held_cipher;
  logic [7:0] digits_seen;
  bit      records_loaded;
  byte     kinds[$];
  int      arg_a[$];
  int      arg_b[$];

  enigma_top dut (
    .clk_100_passthrough (clk_100_passthrough),
    .rst_n               (rst_n),
    .ir_in               (ir_in),
    .sw                  (sw),
    .config_load         (config_load),
    .ready               (ready),
    .cipher_letter       (cipher_letter),
    .cipher_valid        (cipher_valid),
    .plain_letter        (plain_letter),
    .plain_valid         (plain_valid),
    .seg_an              (seg_an),
    .seg_cat             (seg_cat)
  );

  initial begin
    clk_100_passthrough = 1'b0;
    forever #50 clk_100_passthrough = ~clk_100_passthrough;
  end

  always @(posedge clk_100_passthrough) cyc <= cyc + 1;

  // standard hex font, gfedcba, lit high
  function automatic logic [6:0] hex_segments(logic [3:0] v);
    case (v)
      4'h0: return 7'b0111111;
      4'h1: return 7'b0000110;
      4'h2: return 7'b1011011;
      4'h3: return 7'b1001111;
      4'h4: return 7'b1100110;
      4'h5: return 7'b1101101;
      4'h6: return 7'b1111101;
      4'h7: return 7'b0000111;
      4'h8: return 7'b1111111;
      4'h9: return 7'b1101111;
      4'ha: return 7'b1110111;
      4'hb: return 7'b1111100;
      4'hc: return 7'b0111001;
      4'hd: return 7'b1011110;
      4'he: return 7'b1111001;
      default: return 7'b1110001;
    endcase
  endfunction

  // cipher on digits 1:0, plain on 5:4
  function automatic logic [3:0] digit_value(int d, letter_t pl, letter_t ci);
    case (d)
      0: return ci[3:0];
      1: return {3'b000, ci[4]};
      4: return pl[3:0];
      5: return {3'b000, pl[4]};
      default: return 4'h0;
    endcase
  endfunction

  task automatic check_value(string name, int expected, int actual);
    checks++;
    assert (expected == actual) else begin
      value_errors++;
      $display("FAIL %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  task automatic check_true(bit cond, string what);
    checks++;
    assert (cond) else begin
      other_errors++;
      $display("ERROR: %s", what);
    end
  endtask

  // outputs sampled mid-cycle, display checked before the holds move
  always @(negedge clk_100_passthrough) begin : output_monitor
    int         lit;
    logic [6:0] want;
    lit = 0;
    if (!rst_n) begin
      held_plain  = '0;
      held_cipher = '0;
    end else begin
      check_true($countones(~seg_an) <= 1, "more than one display digit lit at once");
      if (!plain_valid && !cipher_valid && $countones(~seg_an) == 1) begin
        for (int d = 0; d < 8; d++) begin
          if (!seg_an[d]) lit = d;
        end
        digits_seen[lit] = 1'b1;
        // active low cathodes
        want = ~hex_segments(digit_value(lit, held_plain, held_cipher));
        check_value($sformatf("display digit %0d", lit), int'(want), int'(seg_cat));
      end
      if (plain_valid) begin
        pv_count++;
        pv_cyc     = cyc;
        pv_letter  = plain_letter;
        held_plain = exp_plain;
      end
      if (cipher_valid) begin
        cv_count++;
        cv_cyc      = cyc;
        cv_letter   = cipher_letter;
        held_cipher = exp_cipher;
      end
    end
  end

  task automatic check_idle_after_reset();
    check_value("reset anodes", 8'hff, int'(seg_an));
    repeat (12) begin
      @(negedge clk_100_passthrough);
      check_true(!plain_valid && !cipher_valid, "valid strobe high after reset");
      check_true(ready, "ready low after reset");
    end
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (8) @(negedge clk_100_passthrough);
    rst_n = 1'b1;
    check_idle_after_reset();
  endtask

  task automatic drive_level(logic level, int cycles);
    ir_in = level;
    repeat (cycles) @(negedge clk_100_passthrough);
  endtask

  task automatic send_letter_frame(letter_t l, output int close_cyc);
    drive_level(1'b0, START_LEN);
    // msb first, the mark after the fifth space closes the frame
    for (int i = `LETTER_W - 1; i >= 0; i--) begin
      drive_level(1'b1, l[i] ? `IR_SPACE1_CYCLES : `IR_SPACE0_CYCLES);
      close_cyc = cyc;
      drive_level(1'b0, `IR_MARK_CYCLES);
    end
    drive_level(1'b1, 8);
  endtask

  task automatic run_letter(int idx, letter_t pl, letter_t expected);
    int    pv0;
    int    cv0;
    int    close_cyc;
    int    waited;
    string name;
    name = $sformatf("letter %0d", idx);
    @(posedge clk_100_passthrough);
    pv0 = pv_count;
    cv0 = cv_count;
    exp_plain  = pl;
    exp_cipher = expected;
    @(negedge clk_100_passthrough);
    send_letter_frame(pl, close_cyc);
    waited = 0;
    while (cv_count == cv0 && waited < LETTER_TIMEOUT) begin
      @(posedge clk_100_passthrough);
      waited++;
    end
    check_true(pv_count == pv0 + 1, {name, ": plain_valid did not pulse once"});
    check_value({name, " plain"}, int'(pl), int'(pv_letter));
    check_value({name, " plain latency"}, RX_LATENCY, pv_cyc - close_cyc);
    check_true(cv_count == cv0 + 1, {name, ": no cipher_valid before timeout"});
    check_value({name, " cipher"}, int'(expected), int'(cv_letter));
    check_value({name, " cipher latency"}, CORE_LATENCY, cv_cyc - pv_cyc);
    @(negedge clk_100_passthrough);
  endtask

  // start mark, one odd space, a mark, then idle
  task automatic run_bad_frame(int idx, int space_len);
    int pv0;
    int cv0;
    @(posedge clk_100_passthrough);
    pv0 = pv_count;
    cv0 = cv_count;
    @(negedge clk_100_passthrough);
    drive_level(1'b0, START_LEN);
    drive_level(1'b1, space_len);
    drive_level(1'b0, `IR_MARK_CYCLES);
    drive_level(1'b1, BAD_WINDOW);
    @(posedge clk_100_passthrough);
    check_true(pv_count == pv0 && cv_count == cv0,
               $sformatf("bad frame %0d produced an output strobe", idx));
    check_true(ready, $sformatf("core busy after bad frame %0d", idx));
    @(negedge clk_100_passthrough);
  endtask

  task automatic run_config(int sel, int pos);
    sw          = {7'b0, sel[8:0]};
    config_load = 1'b1;
    @(negedge clk_100_passthrough);
    config_load = 1'b0;
    @(negedge clk_100_passthrough);
    sw          = {1'b1, pos[14:0]};
    config_load = 1'b1;
    @(negedge clk_100_passthrough);
    config_load = 1'b0;
    repeat (3) @(negedge clk_100_passthrough);
    check_true(ready, "core not ready after configure");
  endtask

  task automatic load_records();
    int    fd;
    int    a;
    int    b;
    byte   c;
    string line;
    string rest;
    fd = $fopen("sim/enigma_stimulus.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("ERROR: cannot open sim/enigma_stimulus.txt");
      return;
    end
    while ($fgets(line, fd) > 0) begin
      c = line.getc(0);
      if (c == "C" || c == "L" || c == "B" || c == "R") begin
        a = 0;
        b = 0;
        rest = (line.len() > 2) ? line.substr(2, line.len() - 1) : "";
        void'($sscanf(rest, "%h %h", a, b));
        kinds.push_back(c);
        arg_a.push_back(a);
        arg_b.push_back(b);
      end
    end
    $fclose(fd);
  endtask

  task automatic report_counts();
    $display("checks %0d, value errors %0d, other errors %0d",
             checks, value_errors, other_errors);
  endtask

  initial begin : watchdog
    wait (records_loaded);
    repeat (kinds.size() * WORST_CYCLES + 2000) @(posedge clk_100_passthrough);
    $display("ERROR: watchdog expired before the records finished");
    report_counts();
    $display(">>> FAIL");
    $finish;
  end

  initial begin : main
    rst_n       = 1'b0;
    ir_in       = 1'b1;
    sw          = '0;
    config_load = 1'b0;
    exp_plain   = '0;
    exp_cipher  = '0;
    digits_seen = '0;
    load_records();
    records_loaded = 1'b1;
    @(negedge clk_100_passthrough);
    apply_reset();
    foreach (kinds[i]) begin
      case (kinds[i])
        "C": run_config(arg_a[i], arg_b[i]);
        "L": run_letter(i, letter_t'(arg_a[i]), letter_t'(arg_b[i]));
        "B": run_bad_frame(i, arg_a[i]);
        default: apply_reset();
      endcase
    end
    check_true(kinds.size() > 0, "no stimulus records were read");
    check_true(digits_seen == 8'hff, "display scan never lit some of the digits");
    report_counts();
    if (value_errors == 0 && other_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+common
common/enigma_pkg.sv
ir/ir_receiver.sv
enigma/rotor_config.sv
enigma/enigma_core.sv
design/seg_display.sv
design/enigma_top.sv
sim/tb_enigma_top.sv
